// File: build.f
+incdir+.
rc5Pkg.sv
rc5KeyIf.sv
rc5CtrlIf.sv
rc5Regs.sv
rc5KeySched.sv
rc5RoundEngine.sv
rc5Core.sv
rc5Core_checker.sv
tb_rc5Core.sv

// File: Makefile
TOP = tb_rc5Core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timing -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: tb_rc5Core.sv
`timescale 1ns/1ps
`include "rc5_config.svh"

module tb_rc5Core
    import rc5Pkg::*;
();

    localparam int busTimeout = 8;
    localparam int pollLimit = 60;
    localparam int numKeys = 3;

    logic clk;
    logic clr;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [3:0] wbAdr;
    rc5Word wbDatIn;
    rc5Word wbDatOut;
    logic wbAck;

    logic verdictShown = 1'b0;
    rc5Word rngState = 32'h66417c16;
    rc5Word keyW [`RC5_KEYWORDS];
    rc5Word modelS [`RC5_T];

    rc5Core DUT (
        .clk     (clk),
        .clr     (clr),
        .i_wbCyc (wbCyc),
        .i_wbStb (wbStb),
        .i_wbWe  (wbWe),
        .i_wbAdr (wbAdr),
        .i_wbDat (wbDatIn),
        .o_wbDat (wbDatOut),
        .o_wbAck (wbAck)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic abortRun(input string reason);
        verdictShown = 1'b1;
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkWord(input string name, input rc5Word got, input rc5Word expected);
        assert (got === expected) else begin
            abortRun($sformatf("ERROR at %0t ns: %s is %h, expected %h",
                               $time, name, got, expected));
        end
    endtask

    // Run stopped by a failing concurrent assertion
    final begin
        if (!verdictShown) begin
            $display("test failed");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone master
    ////////////////////////////////////////////////////////////////////////////

    task automatic busAccess(input logic write, input logic [3:0] adr, input rc5Word wdata,
                             output rc5Word rdata);
        int waited;
        @(posedge clk);
        #2;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = write;
        wbAdr = adr;
        wbDatIn = wdata;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wbAck && waited < busTimeout);
        if (!wbAck) begin
            abortRun($sformatf("no ack for bus access to address %0d", adr));
        end
        rdata = wbDatOut;
        // Request stays up until the edge that ends the ack cycle
        @(posedge clk);
        #2;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic busWrite(input logic [3:0] adr, input rc5Word data);
        rc5Word unused;
        busAccess(1'b1, adr, data, unused);
    endtask

    task automatic busRead(input logic [3:0] adr, output rc5Word data);
        busAccess(1'b0, adr, '0, data);
    endtask

    // Poll STATUS until all bits of mask are set
    task automatic waitStatus(input rc5Word mask, input string what);
        rc5Word status;
        int polls;
        polls = 0;
        busRead(`REG_STATUS, status);
        while ((status & mask) != mask && polls < pollLimit) begin
            busRead(`REG_STATUS, status);
            polls++;
        end
        if ((status & mask) != mask) begin
            abortRun($sformatf("%s did not finish within %0d status polls", what, pollLimit));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // RC5 reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic rc5Word xorshift32(input rc5Word s);
        rc5Word x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic drawWord(output rc5Word value);
        rngState = xorshift32(rngState);
        value = rngState;
    endtask

    function automatic rc5Word rotateLeft(input rc5Word x, input rc5Word amount);
        int n;
        n = int'(amount % 32);
        if (n == 0) begin
            return x;
        end
        return (x << n) | (x >> (32 - n));
    endfunction

    // Standard schedule over keyW into modelS
    task automatic expandKey();
        rc5Word l [`RC5_KEYWORDS];
        rc5Word a;
        rc5Word b;
        int i;
        int j;
        for (int n = 0; n < `RC5_KEYWORDS; n++) begin
            l[n] = keyW[n];
        end
        modelS[0] = `RC5_P;
        for (int n = 1; n < `RC5_T; n++) begin
            modelS[n] = modelS[n - 1] + `RC5_Q;
        end
        a = '0;
        b = '0;
        i = 0;
        j = 0;
        repeat (`RC5_MIXSTEPS) begin
            a = rotateLeft(modelS[i] + a + b, 32'd3);
            modelS[i] = a;
            b = rotateLeft(l[j] + a + b, a + b);
            l[j] = b;
            i = (i + 1) % `RC5_T;
            j = (j + 1) % `RC5_KEYWORDS;
        end
    endtask

    task automatic modelEncrypt(input rc5Word pa, input rc5Word pb,
                                output rc5Word ca, output rc5Word cb);
        rc5Word a;
        rc5Word b;
        a = pa + modelS[0];
        b = pb + modelS[1];
        for (int r = 1; r <= `RC5_ROUNDS; r++) begin
            a = rotateLeft(a ^ b, b) + modelS[2 * r];
            b = rotateLeft(b ^ a, a) + modelS[2 * r + 1];
        end
        ca = a;
        cb = b;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Scenarios
    ////////////////////////////////////////////////////////////////////////////

    // Encrypt against the model, then decrypt back to the plaintext
    task automatic encryptDecrypt(input rc5Word plainA, input rc5Word plainB);
        rc5Word expA;
        rc5Word expB;
        rc5Word gotA;
        rc5Word gotB;
        modelEncrypt(plainA, plainB, expA, expB);
        busWrite(`REG_DINA, plainA);
        busWrite(`REG_DINB, plainB);
        busWrite(`REG_CTRL, 32'h1);
        waitStatus(32'h4, "encryption");
        busRead(`REG_DOUTA, gotA);
        checkWord("DOUTA", gotA, expA);
        busRead(`REG_DOUTB, gotB);
        checkWord("DOUTB", gotB, expB);
        busWrite(`REG_DINA, gotA);
        busWrite(`REG_DINB, gotB);
        busWrite(`REG_CTRL, 32'h3);
        waitStatus(32'h4, "decryption");
        busRead(`REG_DOUTA, gotA);
        checkWord("DOUTA", gotA, plainA);
        busRead(`REG_DOUTB, gotB);
        checkWord("DOUTB", gotB, plainB);
    endtask

    initial begin
        rc5Word rdata;
        rc5Word plainA;
        rc5Word plainB;
        rc5Word expA;
        rc5Word expB;
        clr = 1'b1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatIn = '0;
        repeat (4) @(posedge clk);
        #2;
        clr = 1'b0;

        busRead(`REG_STATUS, rdata);
        checkWord("STATUS", rdata, 32'h0);

        // Go without a key table is dropped
        busWrite(`REG_CTRL, 32'h1);
        repeat (20) @(posedge clk);
        busRead(`REG_STATUS, rdata);
        checkWord("STATUS", rdata, 32'h0);

        for (int k = 0; k < numKeys; k++) begin
            for (int n = 0; n < `RC5_KEYWORDS; n++) begin
                if (k == 0) begin
                    keyW[n] = '0;
                end else begin
                    drawWord(keyW[n]);
                end
                busWrite(`REG_KEY0 + 4'(n), keyW[n]);
            end
            busWrite(`REG_CTRL, 32'h4);
            waitStatus(32'h1, "key expansion");
            expandKey();
            for (int p = 0; p < 2; p++) begin
                if (k == 0 && p == 0) begin
                    plainA = '0;
                    plainB = '0;
                end else begin
                    drawWord(plainA);
                    drawWord(plainB);
                end
                encryptDecrypt(plainA, plainB);
            end
        end

        // Second go, key load and new DINA while busy leave the running block alone
        drawWord(plainA);
        drawWord(plainB);
        modelEncrypt(plainA, plainB, expA, expB);
        busWrite(`REG_DINA, plainA);
        busWrite(`REG_DINB, plainB);
        busWrite(`REG_CTRL, 32'h1);
        busWrite(`REG_DINA, ~plainA);
        busWrite(`REG_CTRL, 32'h1);
        busWrite(`REG_CTRL, 32'h4);
        waitStatus(32'h4, "encryption with a dropped go");
        busRead(`REG_DOUTA, rdata);
        checkWord("DOUTA", rdata, expA);
        busRead(`REG_DOUTB, rdata);
        checkWord("DOUTB", rdata, expB);
        repeat (20) @(posedge clk);
        busRead(`REG_STATUS, rdata);
        checkWord("STATUS", rdata, 32'h5);
        busRead(`REG_DOUTA, rdata);
        checkWord("DOUTA", rdata, expA);
        busRead(`REG_DINA, rdata);
        checkWord("DINA", rdata, ~plainA);

        if (DUT.uChecker.failCount == 0) begin
            verdictShown = 1'b1;
            $display("test passed");
            $finish;
        end else begin
            abortRun("bus or control timing assertions failed");
        end
    end

endmodule

// File: rc5Core_checker.sv
`timescale 1ns/1ps

module rc5Core_checker (
    input logic clk,
    input logic clr,
    input logic i_wbCyc,
    input logic i_wbStb,
    input logic i_wbAck,
    input logic i_go,
    input logic i_keyLoad,
    input logic i_keyReady,
    input logic i_busy,
    input logic i_done
);

    // Read by the testbench at the end of the run
    int failCount = 0;

    logic newReq;
    logic accepted;

    assign newReq = i_wbCyc && i_wbStb && !i_wbAck;
    assign accepted = i_go && i_keyReady && !i_busy;

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone timing
    ////////////////////////////////////////////////////////////////////////////

    ackAfterReq: assert property (@(posedge clk) disable iff (clr) newReq |=> i_wbAck)
        else begin
            $error("ack missing one cycle after a new request");
            failCount++;
        end

    ackOneCycle: assert property (@(posedge clk) disable iff (clr) i_wbAck |=> !i_wbAck)
        else begin
            $error("ack held longer than one cycle");
            failCount++;
        end

    ackOnlyOnReq: assert property (@(posedge clk) disable iff (clr) i_wbAck |-> $past(newReq))
        else begin
            $error("ack without a preceding request");
            failCount++;
        end

    // Everything quiet on the first edge out of reset
    quietAfterReset: assert property (@(posedge clk)
        $fell(clr) |-> !i_wbAck && !i_busy && !i_done && !i_keyReady && !i_go && !i_keyLoad)
        else begin
            $error("outputs or pulses not low after reset");
            failCount++;
        end

    ////////////////////////////////////////////////////////////////////////////
    // Engine and key schedule timing
    ////////////////////////////////////////////////////////////////////////////

    // Accepting edge, then 14 busy cycles, then done
    doneTiming: assert property (@(posedge clk) disable iff (clr)
        accepted |-> ##15 ($rose(i_done) && !i_busy))
        else begin
            $error("done did not rise 14 cycles after an accepted go");
            failCount++;
        end

    keyReadyFalls: assert property (@(posedge clk) disable iff (clr) i_keyLoad |=> !i_keyReady)
        else begin
            $error("keyReady still high after key load");
            failCount++;
        end

    // 26 init plus 78 mix cycles
    keyReadyTiming: assert property (@(posedge clk) disable iff (clr)
        i_keyLoad |-> ##105 $rose(i_keyReady))
        else begin
            $error("keyReady did not rise 104 cycles after key load");
            failCount++;
        end

endmodule

bind rc5Core rc5Core_checker uChecker (
    .clk        (clk),
    .clr        (clr),
    .i_wbCyc    (i_wbCyc),
    .i_wbStb    (i_wbStb),
    .i_wbAck    (o_wbAck),
    .i_go       (ctrlBus.go),
    .i_keyLoad  (keyBus.keyLoad),
    .i_keyReady (keyBus.keyReady),
    .i_busy     (ctrlBus.busy),
    .i_done     (ctrlBus.done)
);

// File: rc5Core.sv
`timescale 1ns/1ps
`include "rc5_config.svh"

module rc5Core (
    input  logic              clk,
    input  logic              clr,
    input  logic              i_wbCyc,
    input  logic              i_wbStb,
    input  logic              i_wbWe,
    input  logic [3:0]        i_wbAdr,
    input  logic [`RC5_W-1:0] i_wbDat,
    output logic [`RC5_W-1:0] o_wbDat,
    output logic              o_wbAck
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal buses
    ////////////////////////////////////////////////////////////////////////////

    rc5CtrlIf ctrlBus ();
    rc5KeyIf keyBus ();

    // Wishbone slave and command registers
    rc5Regs uRegs (
        .clk     (clk),
        .clr     (clr),
        .i_wbCyc (i_wbCyc),
        .i_wbStb (i_wbStb),
        .i_wbWe  (i_wbWe),
        .i_wbAdr (i_wbAdr),
        .i_wbDat (i_wbDat),
        .o_wbDat (o_wbDat),
        .o_wbAck (o_wbAck),
        .ctrl    (ctrlBus.regs),
        .key     (keyBus.regs)
    );

    // Key expansion and round-key table
    rc5KeySched uKeySched (
        .clk (clk),
        .clr (clr),
        .key (keyBus.sched)
    );

    // Shared encrypt and decrypt rounds
    rc5RoundEngine uEngine (
        .clk  (clk),
        .clr  (clr),
        .ctrl (ctrlBus.engine),
        .key  (keyBus.engine)
    );

endmodule

// File: rc5RoundEngine.sv
`timescale 1ns/1ps
`include "rc5_config.svh"

module rc5RoundEngine
    import rc5Pkg::*;
(
    input logic     clk,
    input logic     clr,
    rc5CtrlIf.engine ctrl,
    rc5KeyIf.engine  key
);

    engineState state;
    rc5Op opReg;
    logic [3:0] rnd;
    logic accept;
    logic lastRound;

    rc5Word regA;
    rc5Word regB;
    rc5Word encA;
    rc5Word encB;
    rc5Word decA;
    rc5Word decB;

    // Go only counts when idle with a valid key table
    assign accept = ctrl.go && key.keyReady && (state == ENG_IDLE);
    assign lastRound = (opReg == OP_ENCRYPT) ? (rnd == 4'(`RC5_ROUNDS)) : (rnd == 4'd1);

    // Busy spans the pre, round and post cycles
    assign ctrl.busy = (state != ENG_IDLE);
    // S0 and S1 outside the rounds
    assign key.roundIdx = (state == ENG_ROUND) ? rnd : 4'd0;

    // Encrypt round
    assign encA = rotl(regA ^ regB, regB[4:0]) + key.keyA;
    assign encB = rotl(regB ^ encA, encA[4:0]) + key.keyB;

    // Decrypt round, B undone first
    assign decB = rotr(regB - key.keyB, regA[4:0]) ^ regA;
    assign decA = rotr(regA - key.keyA, decB[4:0]) ^ decB;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            state <= ENG_IDLE;
            opReg <= OP_ENCRYPT;
            rnd <= '0;
            ctrl.done <= 1'b0;
        end else begin
            case (state)
                ENG_IDLE: begin
                    if (accept) begin
                        state <= ENG_PRE;
                        opReg <= ctrl.op;
                        ctrl.done <= 1'b0;
                    end
                end
                ENG_PRE: begin
                    state <= ENG_ROUND;
                    // Encrypt counts up, decrypt counts down
                    rnd <= (opReg == OP_ENCRYPT) ? 4'd1 : 4'(`RC5_ROUNDS);
                end
                ENG_ROUND: begin
                    if (lastRound) begin
                        state <= ENG_POST;
                    end else if (opReg == OP_ENCRYPT) begin
                        rnd <= rnd + 4'd1;
                    end else begin
                        rnd <= rnd - 4'd1;
                    end
                end
                ENG_POST: begin
                    state <= ENG_IDLE;
                    ctrl.done <= 1'b1;
                end
                default: begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        case (state)
            ENG_PRE: begin
                regA <= (opReg == OP_ENCRYPT) ? ctrl.dinA + key.keyA : ctrl.dinA;
                regB <= (opReg == OP_ENCRYPT) ? ctrl.dinB + key.keyB : ctrl.dinB;
            end
            ENG_ROUND: begin
                regA <= (opReg == OP_ENCRYPT) ? encA : decA;
                regB <= (opReg == OP_ENCRYPT) ? encB : decB;
            end
            ENG_POST: begin
                // Result only moves here, so it holds while done is high
                ctrl.doutA <= (opReg == OP_ENCRYPT) ? regA : regA - key.keyA;
                ctrl.doutB <= (opReg == OP_ENCRYPT) ? regB : regB - key.keyB;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: rc5KeySched.sv
`timescale 1ns/1ps
`include "rc5_config.svh"

module rc5KeySched
    import rc5Pkg::*;
(
    input logic   clk,
    input logic   clr,
    rc5KeyIf.sched key
);

    keyState state;
    logic [6:0] stepCnt;
    logic [4:0] idxI;
    logic [1:0] idxJ;
    logic [4:0] keyIdx;

    rc5Word sTab [`RC5_T];
    rc5Word lWord [`RC5_KEYWORDS];
    rc5Word initVal;
    rc5Word mixA;
    rc5Word mixB;
    rc5Word nextA;
    rc5Word nextB;

    // One mixing step: A rotates by 3, B by A+B
    assign nextA = rotl(sTab[idxI] + mixA + mixB, 5'd3);
    assign nextB = rotl(lWord[idxJ] + nextA + mixB, nextA[4:0] + mixB[4:0]);

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer, 26 init cycles then 78 mix cycles
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            state <= KEY_IDLE;
            stepCnt <= '0;
            idxI <= '0;
            idxJ <= '0;
        end else if (key.keyLoad) begin
            // A new key restarts from any state
            state <= KEY_INIT;
            stepCnt <= '0;
        end else begin
            case (state)
                KEY_INIT: begin
                    if (stepCnt == 7'(`RC5_T - 1)) begin
                        state <= KEY_MIX;
                        stepCnt <= '0;
                        idxI <= '0;
                        idxJ <= '0;
                    end else begin
                        stepCnt <= stepCnt + 7'd1;
                    end
                end
                KEY_MIX: begin
                    idxI <= (idxI == 5'(`RC5_T - 1)) ? 5'd0 : idxI + 5'd1;
                    // Four key words, j wraps on its own
                    idxJ <= idxJ + 2'd1;
                    if (stepCnt == 7'(`RC5_MIXSTEPS - 1)) begin
                        state <= KEY_READY;
                    end else begin
                        stepCnt <= stepCnt + 7'd1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Table and key words
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (key.keyLoad) begin
            for (int k = 0; k < `RC5_KEYWORDS; k++) begin
                lWord[k] <= key.keyWords[k];
            end
            initVal <= `RC5_P;
        end else begin
            case (state)
                KEY_INIT: begin
                    // S[i] = P + i*Q as a running sum
                    sTab[stepCnt[4:0]] <= initVal;
                    initVal <= initVal + `RC5_Q;
                    mixA <= '0;
                    mixB <= '0;
                end
                KEY_MIX: begin
                    sTab[idxI] <= nextA;
                    lWord[idxJ] <= nextB;
                    mixA <= nextA;
                    mixB <= nextB;
                end
                default: begin
                end
            endcase
        end
    end

    // Round-key read port
    assign keyIdx = {key.roundIdx, 1'b0};
    assign key.keyA = sTab[keyIdx];
    assign key.keyB = sTab[keyIdx + 5'd1];
    assign key.keyReady = (state == KEY_READY);

endmodule

// File: rc5Regs.sv
`timescale 1ns/1ps
`include "rc5_config.svh"

module rc5Regs
    import rc5Pkg::*;
(
    input  logic       clk,
    input  logic       clr,
    input  logic       i_wbCyc,
    input  logic       i_wbStb,
    input  logic       i_wbWe,
    input  logic [3:0] i_wbAdr,
    input  rc5Word     i_wbDat,
    output rc5Word     o_wbDat,
    output logic       o_wbAck,
    rc5CtrlIf.regs     ctrl,
    rc5KeyIf.regs      key
);

    logic wbReq;
    logic wbWrite;
    logic ctrlWrite;
    logic keyHit;
    logic [3:0] keyOff;
    rc5Word readData;

    ////////////////////////////////////////////////////////////////////////////
    // Bus decode
    ////////////////////////////////////////////////////////////////////////////

    // Held request is masked while ack is out, so each access acks once
    assign wbReq = i_wbCyc && i_wbStb && !o_wbAck;
    assign wbWrite = wbReq && i_wbWe;
    assign ctrlWrite = wbWrite && (i_wbAdr == `REG_CTRL);

    // KEY0..KEY3 window, addresses below KEY0 wrap out of range
    assign keyOff = i_wbAdr - `REG_KEY0;
    assign keyHit = (keyOff < 4'(`RC5_KEYWORDS));

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            o_wbAck <= 1'b0;
            ctrl.go <= 1'b0;
            key.keyLoad <= 1'b0;
        end else begin
            o_wbAck <= wbReq;
            // One-cycle command pulses
            ctrl.go <= ctrlWrite && i_wbDat[0];
            // Key table must not change under a running block
            key.keyLoad <= ctrlWrite && i_wbDat[2] && !ctrl.busy;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Data and key registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wbWrite) begin
            case (i_wbAdr)
                `REG_CTRL: begin
                    ctrl.op <= rc5Op'(i_wbDat[1]);
                end
                `REG_DINA: begin
                    ctrl.dinA <= i_wbDat;
                end
                `REG_DINB: begin
                    ctrl.dinB <= i_wbDat;
                end
                default: begin
                    if (keyHit) begin
                        key.keyWords[keyOff[1:0]] <= i_wbDat;
                    end
                end
            endcase
        end
        // Read data lands together with ack
        if (wbReq && !i_wbWe) begin
            o_wbDat <= readData;
        end
    end

    // Read mux, write-only addresses read as zero
    always_comb begin
        case (i_wbAdr)
            `REG_STATUS: begin
                readData = {{(`RC5_W - 3){1'b0}}, ctrl.done, ctrl.busy, key.keyReady};
            end
            `REG_DINA: begin
                readData = ctrl.dinA;
            end
            `REG_DINB: begin
                readData = ctrl.dinB;
            end
            `REG_DOUTA: begin
                readData = ctrl.doutA;
            end
            `REG_DOUTB: begin
                readData = ctrl.doutB;
            end
            default: begin
                readData = '0;
            end
        endcase
    end

endmodule

// File: rc5CtrlIf.sv
`timescale 1ns/1ps

// Commands and data from the register block, results back from the engine
interface rc5CtrlIf import rc5Pkg::*; ();
    logic go;
    rc5Op op;
    rc5Word dinA;
    rc5Word dinB;
    logic busy;
    // Sticky until the next accepted go
    logic done;
    rc5Word doutA;
    rc5Word doutB;

    modport regs (output go, output op, output dinA, output dinB,
                  input busy, input done, input doutA, input doutB);
    modport engine (input go, input op, input dinA, input dinB,
                    output busy, output done, output doutA, output doutB);

endinterface

// File: rc5KeyIf.sv
`timescale 1ns/1ps
`include "rc5_config.svh"

// Key words in, round-key words out
interface rc5KeyIf import rc5Pkg::*; ();
    logic keyLoad;
    rc5Word [`RC5_KEYWORDS-1:0] keyWords;
    logic keyReady;
    // Round index 0 to 12, selects S[2i] and S[2i+1]
    logic [3:0] roundIdx;
    rc5Word keyA;
    rc5Word keyB;

    modport regs (output keyLoad, output keyWords, input keyReady);
    modport sched (input keyLoad, input keyWords, input roundIdx,
                   output keyReady, output keyA, output keyB);
    modport engine (input keyReady, input keyA, input keyB, output roundIdx);

endinterface

// File: rc5Pkg.sv
`include "rc5_config.svh"

package rc5Pkg;

    typedef logic [`RC5_W-1:0] rc5Word;

    typedef enum logic {
        OP_ENCRYPT = 1'b0,
        OP_DECRYPT = 1'b1
    } rc5Op;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_PRE,
        ENG_ROUND,
        ENG_POST
    } engineState;

    typedef enum logic [1:0] {
        KEY_IDLE,
        KEY_INIT,
        KEY_MIX,
        KEY_READY
    } keyState;

    // Rotations by the low five bits, shift of 32 yields zero
    function automatic rc5Word rotl(input rc5Word x, input logic [4:0] n);
        return (x << n) | (x >> (`RC5_W - n));
    endfunction

    function automatic rc5Word rotr(input rc5Word x, input logic [4:0] n);
        return (x >> n) | (x << (`RC5_W - n));
    endfunction

endpackage

// File: rc5_config.svh
`ifndef RC5_CONFIG_SVH
`define RC5_CONFIG_SVH

// RC5-32/12/16 sizes
`define RC5_W         32
`define RC5_ROUNDS    12
`define RC5_T         26
`define RC5_KEYWORDS  4
`define RC5_MIXSTEPS  78

// Magic constants for the key table
`define RC5_P         32'hB7E15163
`define RC5_Q         32'h9E3779B9

// Wishbone word addresses
`define REG_CTRL      4'd0
`define REG_STATUS    4'd1
`define REG_DINA      4'd2
`define REG_DINB      4'd3
`define REG_DOUTA     4'd4
`define REG_DOUTB     4'd5
`define REG_KEY0      4'd8

`endif
